// File: hw/board_pkg.sv
package board_pkg;

  ////////////////////
  // widths
  ////////////////////

  // fan switch setting, also the pwm step count
  typedef logic [3:0] fan_level_t;

  // spi host chip selects
  typedef logic [1:0] spi_cs_t;

  // spi host data lines, quad capable
  typedef logic [3:0] spi_sd_t;

  ////////////////////
  // defaults
  ////////////////////

  // soc_clk cycles per rtc period, 50 MHz down to 1 MHz
  localparam int unsigned RtcDivDefault = 50;
  // soc_clk cycles per pwm step
  localparam int unsigned FanStepCyclesDefault = 4;
  // steps per pwm period, one per fan setting
  localparam int unsigned FanSteps = 16;

endpackage

// File: hw/regbus_pkg.sv
package regbus_pkg;

  ////////////////////
  // bus types
  ////////////////////

  // byte address on the register bus
  typedef logic [31:0] reg_addr_t;

  // one register word
  typedef logic [31:0] reg_data_t;

  ////////////////////
  // error response
  ////////////////////

  // read value on an unmapped access
  // easy to spot in a memory dump
  localparam reg_data_t RegErrValue = 32'hBADC_AB1E;

endpackage

// File: hw/spi_host_if.sv
`timescale 1ns/1ps

// soc spi host pins as seen from the board
interface spi_host_if;

  // serial clock and its output enable
  logic                 sck;
  logic                 sck_en;
  // chip selects, active low, with enables
  board_pkg::spi_cs_t   csb;
  board_pkg::spi_cs_t   csb_en;
  // data lines out, enables, and back in
  board_pkg::spi_sd_t   sd_out;
  board_pkg::spi_sd_t   sd_en;
  board_pkg::spi_sd_t   sd_in;

  // soc side drives everything but the return data
  modport host (
    output sck, sck_en, csb, csb_en, sd_out, sd_en,
    input  sd_in
  );

  // pad side only returns the input lines
  modport pad (
    input  sck, sck_en, csb, csb_en, sd_out, sd_en,
    output sd_in
  );

endinterface

// File: hw/reg_bus_if.sv
`timescale 1ns/1ps

// one register bus port, request and response
interface reg_bus_if;

  // request, one access per valid cycle
  logic                   valid;
  logic                   write;
  regbus_pkg::reg_addr_t  addr;
  regbus_pkg::reg_data_t  wdata;
  // response, one cycle after each valid cycle
  logic                   ready;
  regbus_pkg::reg_data_t  rdata;
  logic                   error;

  // requester side
  modport master (
    output valid, write, addr, wdata,
    input  ready, rdata, error
  );

  // responder side, no back-pressure
  modport slave (
    input  valid, write, addr, wdata,
    output ready, rdata, error
  );

endinterface

// File: hw/rtc_tick_gen.sv
`timescale 1ns/1ps

module rtc_tick_gen #(
  // soc_clk cycles per rtc period, must be even
  parameter int unsigned RtcDiv = board_pkg::RtcDivDefault
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // half period, one level phase
  localparam int unsigned Half = RtcDiv / 2;
  localparam int unsigned CntW = (Half > 1) ? $clog2(Half) : 1;
  localparam logic [CntW-1:0] CntLast = CntW'(Half - 1);

  logic [CntW-1:0] cnt_q;
  logic            rtc_q;
  logic            wrap;

  // terminal count reached, flip the level
  assign wrap = (cnt_q == CntLast);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  // counter stays in range, level only moves on a wrap
  a_rtc_wrap : assert property (@(posedge soc_clk) disable iff (!rst_n)
    (cnt_q <= CntLast) && ((rtc_q != $past(rtc_q)) -> ($past(cnt_q) == CntLast)));

endmodule

// File: hw/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm #(
  // soc_clk cycles per pwm step
  parameter int unsigned FanStepCycles = board_pkg::FanStepCyclesDefault
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  board_pkg::fan_level_t fan_sw_i,
  output logic                  fan_pwm_o
);

  localparam int unsigned PreW = (FanStepCycles > 1) ? $clog2(FanStepCycles) : 1;
  localparam logic [PreW-1:0] PreLast = PreW'(FanStepCycles - 1);
  localparam board_pkg::fan_level_t StepLast = board_pkg::fan_level_t'(board_pkg::FanSteps - 1);

  logic [PreW-1:0]       pre_q;
  board_pkg::fan_level_t step_q;
  // setting held for the whole period
  board_pkg::fan_level_t level_q;
  logic                  step_adv;
  logic                  period_end;

  assign step_adv   = (pre_q == PreLast);
  assign period_end = step_adv && (step_q == StepLast);

  ////////////////////
  // prescaler and step
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= '0;
      step_q  <= '0;
      level_q <= '0;
    end else begin
      pre_q <= step_adv ? '0 : pre_q + 1'b1;
      if (step_adv) begin
        // wraps to step 0 after the last step
        step_q <= step_q + 1'b1;
      end
      if (period_end) begin
        // new setting takes effect at the next period start
        level_q <= fan_sw_i;
      end
    end
  end

  // high steps come first in the period
  assign fan_pwm_o = (step_q < level_q);

  // a zero setting keeps the fan off from the period start
  a_fan_off : assert property (@(posedge soc_clk) disable iff (!rst_n)
    period_end |=> (fan_pwm_o == ($past(fan_sw_i) != '0)));

endmodule

// File: hw/sd_spi_pads.sv
`timescale 1ns/1ps

// sd card in spi mode on the soc spi host
module sd_spi_pads (
  input  logic           soc_clk,
  input  logic           rst_n,
  spi_host_if.pad        spi,
  output logic           sd_sclk_o,
  output logic           sd_cmd_o,
  output logic           sd_dat3_o,
  input  logic           sd_dat0_i
);

  logic sclk_q;
  logic cmd_q;
  logic dat3_q;
  logic dat0_q;

  ////////////////////
  // pad flops
  ////////////////////

  // disabled lines sit at the idle level, high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_q <= 1'b1;
      cmd_q  <= 1'b1;
      dat3_q <= 1'b1;
      dat0_q <= 1'b0;
    end else begin
      // sck -> sd clk
      sclk_q <= spi.sck_en    ? spi.sck       : 1'b1;
      // cs0 -> dat3
      dat3_q <= spi.csb_en[0] ? spi.csb[0]    : 1'b1;
      // mosi -> cmd
      cmd_q  <= spi.sd_en[0]  ? spi.sd_out[0] : 1'b1;
      // miso from dat0
      dat0_q <= sd_dat0_i;
    end
  end

  assign sd_sclk_o = sclk_q;
  assign sd_cmd_o  = cmd_q;
  assign sd_dat3_o = dat3_q;

  // host reads miso on bit 1, rest low
  assign spi.sd_in = {2'b00, dat0_q, 1'b0};

  // cmd idles high once the host lets go of the line
  a_cmd_idle : assert property (@(posedge soc_clk) disable iff (!rst_n)
    !spi.sd_en[0] |=> sd_cmd_o);

endmodule

// File: hw/reg_err_slave.sv
`timescale 1ns/1ps

// answers any register access with an error
module reg_err_slave (
  input  logic      soc_clk,
  input  logic      rst_n,
  reg_bus_if.slave  bus
);

  logic                  ready_q;
  logic                  error_q;
  regbus_pkg::reg_data_t rdata_q;

  ////////////////////
  // response
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
      rdata_q <= '0;
    end else if (bus.valid) begin
      ready_q <= 1'b1;
      error_q <= 1'b1;
      // reads see the marker, writes get zero
      rdata_q <= bus.write ? '0 : regbus_pkg::RegErrValue;
    end else begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end
  end

  assign bus.ready = ready_q;
  assign bus.error = error_q;
  assign bus.rdata = rdata_q;

  // one response per valid cycle, exactly one cycle later
  a_ready_lag : assert property (@(posedge soc_clk) disable iff (!rst_n)
    bus.ready == $past(bus.valid));

  // requester must present a clean request
  a_req_known : assert property (@(posedge soc_clk) disable iff (!rst_n)
    bus.valid |-> !$isunknown({bus.write, bus.addr, bus.wdata}));

endmodule

// File: hw/board_glue_top.sv
`timescale 1ns/1ps

module board_glue_top #(
  parameter int unsigned RtcDiv        = board_pkg::RtcDivDefault,
  parameter int unsigned FanStepCycles = board_pkg::FanStepCyclesDefault
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // fan
  input  board_pkg::fan_level_t fan_sw_i,
  output logic                  fan_pwm_o,
  // rtc level to the soc
  output logic                  rtc_o,
  // soc spi host
  input  logic                  spi_sck_i,
  input  logic                  spi_sck_en_i,
  input  board_pkg::spi_cs_t    spi_csb_i,
  input  board_pkg::spi_cs_t    spi_csb_en_i,
  input  board_pkg::spi_sd_t    spi_sd_i,
  input  board_pkg::spi_sd_t    spi_sd_en_i,
  output board_pkg::spi_sd_t    spi_sd_in_o,
  // sd card pins
  output logic                  sd_sclk_o,
  output logic                  sd_cmd_o,
  output logic                  sd_dat3_o,
  input  logic                  sd_dat0_i,
  // external register bus
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  regbus_pkg::reg_addr_t reg_addr_i,
  input  regbus_pkg::reg_data_t reg_wdata_i,
  output logic                  reg_ready_o,
  output logic                  reg_error_o,
  output regbus_pkg::reg_data_t reg_rdata_o
);

  ////////////////////
  // rtc
  ////////////////////

  rtc_tick_gen #(
    .RtcDiv (RtcDiv)
  ) i_rtc (
    .soc_clk (soc_clk),
    .rst_n   (rst_n),
    .rtc_o   (rtc_o)
  );

  ////////////////////
  // fan
  ////////////////////

  fan_pwm #(
    .FanStepCycles (FanStepCycles)
  ) i_fan (
    .soc_clk   (soc_clk),
    .rst_n     (rst_n),
    .fan_sw_i  (fan_sw_i),
    .fan_pwm_o (fan_pwm_o)
  );

  ////////////////////
  // sd over spi
  ////////////////////

  spi_host_if spi ();

  // soc host side of the bundle
  assign spi.sck    = spi_sck_i;
  assign spi.sck_en = spi_sck_en_i;
  assign spi.csb    = spi_csb_i;
  assign spi.csb_en = spi_csb_en_i;
  assign spi.sd_out = spi_sd_i;
  assign spi.sd_en  = spi_sd_en_i;
  assign spi_sd_in_o = spi.sd_in;

  sd_spi_pads i_sd_pads (
    .soc_clk   (soc_clk),
    .rst_n     (rst_n),
    .spi       (spi),
    .sd_sclk_o (sd_sclk_o),
    .sd_cmd_o  (sd_cmd_o),
    .sd_dat3_o (sd_dat3_o),
    .sd_dat0_i (sd_dat0_i)
  );

  ////////////////////
  // regbus error
  ////////////////////

  reg_bus_if rbus ();

  assign rbus.valid = reg_valid_i;
  assign rbus.write = reg_write_i;
  assign rbus.addr  = reg_addr_i;
  assign rbus.wdata = reg_wdata_i;
  assign reg_ready_o = rbus.ready;
  assign reg_error_o = rbus.error;
  assign reg_rdata_o = rbus.rdata;

  reg_err_slave i_reg_err (
    .soc_clk (soc_clk),
    .rst_n   (rst_n),
    .bus     (rbus)
  );

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

// free running soc_clk and power-on reset
module tb_clkgen #(
  parameter int unsigned PeriodNs  = 8,
  parameter int unsigned RstCycles = 16
) (
  output logic soc_clk_o,
  output logic rst_n_o
);

  initial begin
    soc_clk_o = 1'b0;
    forever #(PeriodNs / 2) soc_clk_o = ~soc_clk_o;
  end

  // held low for RstCycles, let go on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge soc_clk_o);
    @(negedge soc_clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: bench/tb_board_glue.sv
`timescale 1ns/1ps

module tb_board_glue;

  localparam int unsigned RtcDiv        = board_pkg::RtcDivDefault;
  localparam int unsigned FanStepCycles = board_pkg::FanStepCyclesDefault;
  localparam int unsigned FanPeriod     = board_pkg::FanSteps * FanStepCycles;
  localparam int unsigned RstCycles     = 16;
  localparam int unsigned RtcPeriods    = 4;
  // read value of an unmapped register
  localparam regbus_pkg::reg_data_t ErrRead = 32'hBADC_AB1E;

  localparam logic [1:0] KindFan = 2'd0;
  localparam logic [1:0] KindReg = 2'd1;
  localparam logic [1:0] KindPad = 2'd2;

  // one table row, stimulus plus expected response
  typedef struct packed {
    logic [1:0]            kind;
    board_pkg::fan_level_t level;
    logic                  write;
    logic                  chain;
    regbus_pkg::reg_addr_t addr;
    regbus_pkg::reg_data_t wdata;
    regbus_pkg::reg_data_t exp_data;
    logic                  sck;
    logic                  sck_en;
    board_pkg::spi_cs_t    csb;
    board_pkg::spi_cs_t    csb_en;
    board_pkg::spi_sd_t    sd;
    board_pkg::spi_sd_t    sd_en;
    logic                  dat0;
    // sclk, cmd, dat3
    logic [2:0]            exp_pads;
    board_pkg::spi_sd_t    exp_sd_in;
  } entry_t;

  entry_t      tbl[$];
  string       names[$];
  int unsigned cycles;
  int unsigned cycle_limit;

  logic                  soc_clk;
  logic                  rst_n;
  board_pkg::fan_level_t fan_sw_i;
  logic                  fan_pwm_o;
  logic                  rtc_o;
  logic                  spi_sck_i;
  logic                  spi_sck_en_i;
  board_pkg::spi_cs_t    spi_csb_i;
  board_pkg::spi_cs_t    spi_csb_en_i;
  board_pkg::spi_sd_t    spi_sd_i;
  board_pkg::spi_sd_t    spi_sd_en_i;
  board_pkg::spi_sd_t    spi_sd_in_o;
  logic                  sd_sclk_o;
  logic                  sd_cmd_o;
  logic                  sd_dat3_o;
  logic                  sd_dat0_i;
  logic                  reg_valid_i;
  logic                  reg_write_i;
  regbus_pkg::reg_addr_t reg_addr_i;
  regbus_pkg::reg_data_t reg_wdata_i;
  logic                  reg_ready_o;
  logic                  reg_error_o;
  regbus_pkg::reg_data_t reg_rdata_o;

  tb_clkgen #(
    .PeriodNs  (8),
    .RstCycles (RstCycles)
  ) i_clkgen (
    .soc_clk_o (soc_clk),
    .rst_n_o   (rst_n)
  );

  board_glue_top #(
    .RtcDiv        (RtcDiv),
    .FanStepCycles (FanStepCycles)
  ) uut (
    .soc_clk      (soc_clk),
    .rst_n        (rst_n),
    .fan_sw_i     (fan_sw_i),
    .fan_pwm_o    (fan_pwm_o),
    .rtc_o        (rtc_o),
    .spi_sck_i    (spi_sck_i),
    .spi_sck_en_i (spi_sck_en_i),
    .spi_csb_i    (spi_csb_i),
    .spi_csb_en_i (spi_csb_en_i),
    .spi_sd_i     (spi_sd_i),
    .spi_sd_en_i  (spi_sd_en_i),
    .spi_sd_in_o  (spi_sd_in_o),
    .sd_sclk_o    (sd_sclk_o),
    .sd_cmd_o     (sd_cmd_o),
    .sd_dat3_o    (sd_dat3_o),
    .sd_dat0_i    (sd_dat0_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_ready_o  (reg_ready_o),
    .reg_error_o  (reg_error_o),
    .reg_rdata_o  (reg_rdata_o)
  );

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic compare_level(input string name, input board_pkg::fan_level_t exp,
                               input board_pkg::fan_level_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "duty mismatch");
    end
  endtask

  task automatic compare_data(input string name, input regbus_pkg::reg_data_t exp,
                              input regbus_pkg::reg_data_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  ////////////////////
  // table rows
  ////////////////////

  task automatic add_fan_entry(input string name, input board_pkg::fan_level_t level);
    entry_t e;
    e = '0;
    e.kind  = KindFan;
    e.level = level;
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic add_reg_entry(input string name, input logic write, input logic chain);
    entry_t e;
    e = '0;
    e.kind  = KindReg;
    e.write = write;
    // chained rows keep valid high from the row before
    e.chain = chain;
    e.addr  = $urandom() & 32'hFFFF_FFFC;
    e.wdata = write ? $urandom() : 32'h0;
    // reads get the error marker, writes zero
    e.exp_data = write ? 32'h0 : ErrRead;
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic add_pad_entry(input string name, input logic [14:0] s);
    entry_t e;
    e = '0;
    e.kind   = KindPad;
    e.sck    = s[0];
    e.sck_en = s[1];
    e.csb    = s[3:2];
    e.csb_en = s[5:4];
    e.sd     = s[9:6];
    e.sd_en  = s[13:10];
    e.dat0   = s[14];
    // enabled lines pass through, disabled lines idle high
    e.exp_pads = {s[1] ? s[0] : 1'b1, s[10] ? s[6] : 1'b1, s[4] ? s[2] : 1'b1};
    // miso returns on bit 1 only
    e.exp_sd_in = {2'b00, s[14], 1'b0};
    tbl.push_back(e);
    names.push_back(name);
  endtask

  ////////////////////
  // row runners
  ////////////////////

  // level flips every half period, counted from reset release
  task automatic check_rtc();
    int unsigned k;
    for (k = 1; k <= RtcPeriods * RtcDiv; k++) begin
      @(negedge soc_clk);
      compare_bit($sformatf("rtc_level cycle %0d", k), ((k / (RtcDiv / 2)) % 2) == 1, rtc_o);
    end
  endtask

  task automatic measure_fan(input int idx);
    int unsigned high;
    fan_sw_i = tbl[idx].level;
    // a full period so the new setting gets latched
    repeat (FanPeriod) @(negedge soc_clk);
    high = 0;
    // any whole period window sees the same duty
    repeat (FanPeriod) begin
      @(negedge soc_clk);
      if (fan_pwm_o) high++;
    end
    compare_level(names[idx], tbl[idx].level, board_pkg::fan_level_t'(high / FanStepCycles));
    compare_bit({names[idx], " exact"}, 1'b1, high == tbl[idx].level * FanStepCycles);
  endtask

  task automatic access_reg(input int idx);
    logic next_chained;
    reg_valid_i = 1'b1;
    reg_write_i = tbl[idx].write;
    reg_addr_i  = tbl[idx].addr;
    reg_wdata_i = tbl[idx].wdata;
    @(negedge soc_clk);
    compare_bit({names[idx], " ready"}, 1'b1, reg_ready_o);
    compare_bit({names[idx], " error"}, 1'b1, reg_error_o);
    compare_data(names[idx], tbl[idx].exp_data, reg_rdata_o);
    next_chained = (idx + 1 < tbl.size()) && (tbl[idx + 1].kind == KindReg) &&
                   tbl[idx + 1].chain;
    // end of a burst, bus goes quiet
    if (!next_chained) begin
      reg_valid_i = 1'b0;
      @(negedge soc_clk);
      compare_bit({names[idx], " idle"}, 1'b0, reg_ready_o);
      compare_bit({names[idx], " idle error"}, 1'b0, reg_error_o);
    end
  endtask

  task automatic drive_pads(input int idx);
    int b;
    spi_sck_i    = tbl[idx].sck;
    spi_sck_en_i = tbl[idx].sck_en;
    spi_csb_i    = tbl[idx].csb;
    spi_csb_en_i = tbl[idx].csb_en;
    spi_sd_i     = tbl[idx].sd;
    spi_sd_en_i  = tbl[idx].sd_en;
    sd_dat0_i    = tbl[idx].dat0;
    // pad flops, one cycle later
    @(negedge soc_clk);
    compare_bit({names[idx], " sclk"}, tbl[idx].exp_pads[2], sd_sclk_o);
    compare_bit({names[idx], " cmd"}, tbl[idx].exp_pads[1], sd_cmd_o);
    compare_bit({names[idx], " dat3"}, tbl[idx].exp_pads[0], sd_dat3_o);
    for (b = 0; b < 4; b++) begin
      compare_bit($sformatf("%s sd_in[%0d]", names[idx], b), tbl[idx].exp_sd_in[b],
                  spi_sd_in_o[b]);
    end
  endtask

  ////////////////////
  // watchdog
  ////////////////////

  always @(posedge soc_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int i;
    logic [31:0] rnd;
    void'($urandom(32'h58affa00));
    cycles       = 0;
    fan_sw_i     = '0;
    spi_sck_i    = 1'b0;
    spi_sck_en_i = 1'b0;
    spi_csb_i    = '1;
    spi_csb_en_i = '0;
    spi_sd_i     = '0;
    spi_sd_en_i  = '0;
    sd_dat0_i    = 1'b0;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;

    // pads driven and idle
    add_pad_entry("pad_on_high", 15'b1_0001_0001_01_11_1_1);
    add_pad_entry("pad_on_low", 15'b0_0001_1110_01_10_1_0);
    add_pad_entry("pad_idle", 15'b1_0000_0000_00_00_0_0);
    // single accesses, then a burst of four
    add_reg_entry("reg_read", 1'b0, 1'b0);
    add_reg_entry("reg_write", 1'b1, 1'b0);
    add_reg_entry("reg_b2b_read", 1'b0, 1'b0);
    add_reg_entry("reg_b2b_write", 1'b1, 1'b1);
    add_reg_entry("reg_b2b_read2", 1'b0, 1'b1);
    add_reg_entry("reg_b2b_write2", 1'b1, 1'b1);
    add_fan_entry("fan_off", 4'd0);
    add_fan_entry("fan_min", 4'd1);
    add_fan_entry("fan_half", 4'd8);
    add_fan_entry("fan_full", 4'd15);
    for (i = 0; i < 6; i++) begin
      rnd = $urandom();
      add_pad_entry($sformatf("pad_rand_%0d", i), rnd[14:0]);
    end
    cycle_limit = RstCycles + tbl.size() * 2 * FanPeriod + RtcPeriods * RtcDiv + 100;

    @(posedge rst_n);
    check_rtc();
    for (i = 0; i < tbl.size(); i++) begin
      case (tbl[i].kind)
        KindFan: measure_fan(i);
        KindReg: access_reg(i);
        default: drive_pads(i);
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: vlog.f
hw/board_pkg.sv
hw/regbus_pkg.sv
hw/spi_host_if.sv
hw/reg_bus_if.sv
hw/rtc_tick_gen.sv
hw/fan_pwm.sv
hw/sd_spi_pads.sv
hw/reg_err_slave.sv
hw/board_glue_top.sv
bench/tb_clkgen.sv
bench/tb_board_glue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_glue
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "no verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
